//--- include/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Byte offset within a line, 16 bytes or four words
`define FETCH_OFFSET_BITS 4
// Line index, four lines
`define FETCH_INDEX_BITS 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map and bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define FETCH_RESET_PC 32'h3000_0000
// Top address byte of the on-chip region that bypasses the cache
`define FETCH_UNCACHED_TOP 8'h0f
// arlen for a full line, four beats
`define FETCH_BURST_LEN 3

`endif

//--- src/fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  // Plain 32-bit word or byte address
  typedef logic [31:0] word_t;

  // Address fields above the line offset
  typedef logic [31-`FETCH_OFFSET_BITS-`FETCH_INDEX_BITS:0] tag_t;
  typedef logic [`FETCH_INDEX_BITS-1:0] index_t;

  // Word 0 of the line in the low 32 bits
  typedef logic [(8 << `FETCH_OFFSET_BITS)-1:0] line_t;

  // One fetched instruction toward decode
  typedef struct packed {
    word_t pc;
    word_t inst;
    logic  fault;
  } fetch_entry_t;

endpackage

`default_nettype wire

//--- src/fetch_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_sequencer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   redirect,
  input  fetch_pkg::word_t       redirect_pc,
  output fetch_pkg::word_t       lookup_pc,
  input  logic                   hit,
  input  fetch_pkg::line_t       hit_line,
  output logic                   fill_req,
  output fetch_pkg::word_t       fill_addr,
  output logic                   fill_uncached,
  input  logic                   fill_done,
  input  fetch_pkg::line_t       fill_line,
  input  fetch_pkg::word_t       fill_word,
  output logic                   line_we,
  output fetch_pkg::index_t      line_index,
  output fetch_pkg::tag_t        line_tag,
  output fetch_pkg::line_t       line_data,
  output logic                   push,
  output fetch_pkg::fetch_entry_t push_entry,
  input  logic                   full,
  output logic                   drop
);

  typedef enum logic [1:0] {st_lookup, st_wait_fill, st_halted} state_t;

  state_t           state;
  fetch_pkg::word_t pc;
  fetch_pkg::word_t hit_word;
  logic             discard;
  logic             aligned;
  logic             uncached;
  logic             take_hit;
  logic             take_fault;
  logic             take_word;
  logic             start_fill;

  assign lookup_pc = pc;
  assign aligned   = (pc[1:0] == 2'b00);
  assign uncached  = (pc[31:24] == `FETCH_UNCACHED_TOP);
  assign hit_word  = hit_line[pc[`FETCH_OFFSET_BITS-1:2]*32 +: 32];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decisions for this cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign take_hit   = (state == st_lookup) && aligned && hit && !full && !redirect;
  assign take_fault = (state == st_lookup) && !aligned && !full && !redirect;
  // Uncached fill only starts with queue room, so the word always has a slot
  assign start_fill = (state == st_lookup) && aligned && !hit && (!uncached || !full) &&
                      !redirect;
  assign take_word  = (state == st_wait_fill) && fill_done && fill_uncached && !discard &&
                      !redirect;

  assign push     = take_hit || take_fault || take_word;
  assign drop     = redirect;
  assign fill_req = (state == st_wait_fill);

  // Line write always uses the fill address, even after a redirect
  assign line_we    = (state == st_wait_fill) && fill_done && !fill_uncached;
  assign line_index = fill_addr[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
  assign line_tag   = fill_addr[31:`FETCH_OFFSET_BITS+`FETCH_INDEX_BITS];
  assign line_data  = fill_line;

  always_comb begin
    push_entry = '0;
    push_entry.pc = pc;
    if (take_word) begin
      push_entry.inst = fill_word;
    end else if (take_hit) begin
      push_entry.inst = hit_word;
    end
    push_entry.fault = take_fault;
  end

  always_ff @(posedge clock) begin
    if (start_fill) begin
      fill_addr     <= uncached ? pc : {pc[31:`FETCH_OFFSET_BITS], {`FETCH_OFFSET_BITS{1'b0}}};
      fill_uncached <= uncached;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= st_lookup;
      pc      <= `FETCH_RESET_PC;
      discard <= 1'b0;
    end else begin
      if (redirect) begin
        pc <= redirect_pc;
      end else if (take_hit || take_word) begin
        pc <= pc + 32'd4;
      end
      case (state)
        st_lookup: begin
          if (start_fill) begin
            state <= st_wait_fill;
          end else if (take_fault) begin
            state <= st_halted;
          end
        end
        st_wait_fill: begin
          if (fill_done) begin
            state   <= st_lookup;
            discard <= 1'b0;
          end else if (redirect) begin
            discard <= 1'b1;
          end
        end
        default: begin
          if (redirect) state <= st_lookup;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/icache_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module icache_array (
  input  logic              clock,
  input  logic              reset,
  input  logic              flush,
  input  fetch_pkg::word_t  lookup_pc,
  output logic              hit,
  output fetch_pkg::line_t  hit_line,
  input  logic              line_we,
  input  fetch_pkg::index_t line_index,
  input  fetch_pkg::tag_t   line_tag,
  input  fetch_pkg::line_t  line_data
);

  localparam int num_lines = 1 << `FETCH_INDEX_BITS;

  fetch_pkg::tag_t   tags [0:num_lines-1];
  fetch_pkg::line_t  lines [0:num_lines-1];
  logic [num_lines-1:0] valid;

  fetch_pkg::index_t lookup_index;
  fetch_pkg::tag_t   lookup_tag;
  logic              uncached;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign lookup_index = lookup_pc[`FETCH_OFFSET_BITS +: `FETCH_INDEX_BITS];
  assign lookup_tag   = lookup_pc[31:`FETCH_OFFSET_BITS+`FETCH_INDEX_BITS];
  assign uncached     = (lookup_pc[31:24] == `FETCH_UNCACHED_TOP);

  assign hit      = !uncached && valid[lookup_index] && (tags[lookup_index] == lookup_tag);
  assign hit_line = lines[lookup_index];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Update
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Flush first, so a line landing in the same cycle survives
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (flush) valid <= '0;
      if (line_we) valid[line_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (line_we) begin
      tags[line_index]  <= line_tag;
      lines[line_index] <= line_data;
    end
  end

endmodule

`default_nettype wire

//--- src/refill_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module refill_engine (
  input  logic             clock,
  input  logic             reset,
  input  logic             fill_req,
  input  fetch_pkg::word_t fill_addr,
  input  logic             fill_uncached,
  output logic             fill_done,
  output fetch_pkg::line_t fill_line,
  output fetch_pkg::word_t fill_word,
  output fetch_pkg::word_t araddr,
  output logic [7:0]       arlen,
  output logic             arvalid,
  input  logic             arready,
  input  fetch_pkg::word_t rdata,
  input  logic             rvalid,
  output logic             rready,
  input  logic             rlast
);

  localparam int line_bits = $bits(fetch_pkg::line_t);

  typedef enum logic [1:0] {st_idle, st_addr, st_data, st_done} state_t;

  state_t           state;
  fetch_pkg::line_t line_buf;

  assign arvalid   = (state == st_addr);
  assign rready    = (state == st_data);
  assign fill_done = (state == st_done);
  assign fill_line = line_buf;
  // Single uncached beat lands in the top word
  assign fill_word = line_buf[line_bits-1 -: 32];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (fill_req) state <= st_addr;
        end
        st_addr: begin
          if (arready) state <= st_data;
        end
        st_data: begin
          if (rvalid && rlast) state <= st_done;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Address and beat capture
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (state == st_idle && fill_req) begin
      araddr <= fill_addr;
      arlen  <= fill_uncached ? 8'd0 : 8'(`FETCH_BURST_LEN);
    end
    // Beats shift in from the top, first beat ends as word 0
    if (state == st_data && rvalid) begin
      line_buf <= {rdata, line_buf[line_bits-1:32]};
    end
  end

endmodule

`default_nettype wire

//--- src/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
  parameter type entry_t = fetch_pkg::fetch_entry_t,
  parameter int  DEPTH   = 2
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   drop,
  input  logic   push,
  input  entry_t push_data,
  output logic   full,
  output logic   out_valid,
  input  logic   out_ready,
  output entry_t out_data
);

  localparam int ptr_bits = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_bits = $clog2(DEPTH + 1);

  entry_t              mem [0:DEPTH-1];
  logic [ptr_bits-1:0] rd_ptr;
  logic [ptr_bits-1:0] wr_ptr;
  logic [cnt_bits-1:0] count;
  logic                do_push;
  logic                do_pop;

  assign full      = (count == cnt_bits'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign do_push   = push && !full;
  assign do_pop    = out_valid && out_ready;

  always_ff @(posedge clock) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

  // Drop discards every entry, including one pushed this cycle
  always_ff @(posedge clock) begin
    if (reset || drop) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == ptr_bits'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == ptr_bits'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic             clock,
  input  logic             reset,
  input  logic             redirect,
  input  fetch_pkg::word_t redirect_pc,
  input  logic             flush_cache,
  output fetch_pkg::word_t araddr,
  output logic [7:0]       arlen,
  output logic             arvalid,
  input  logic             arready,
  input  fetch_pkg::word_t rdata,
  input  logic             rvalid,
  output logic             rready,
  input  logic             rlast,
  output logic             out_valid,
  input  logic             out_ready,
  output fetch_pkg::word_t out_pc,
  output fetch_pkg::word_t out_inst,
  output logic             out_fault
);

  fetch_pkg::word_t        lookup_pc, fill_addr, fill_word;
  fetch_pkg::line_t        hit_line, fill_line, line_data;
  fetch_pkg::index_t       line_index;
  fetch_pkg::tag_t         line_tag;
  fetch_pkg::fetch_entry_t push_entry, out_data;
  logic hit, fill_req, fill_uncached, fill_done, line_we, push, full, drop;

  fetch_sequencer u_sequencer (
    .clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
    .lookup_pc(lookup_pc), .hit(hit), .hit_line(hit_line),
    .fill_req(fill_req), .fill_addr(fill_addr), .fill_uncached(fill_uncached),
    .fill_done(fill_done), .fill_line(fill_line), .fill_word(fill_word),
    .line_we(line_we), .line_index(line_index), .line_tag(line_tag), .line_data(line_data),
    .push(push), .push_entry(push_entry), .full(full), .drop(drop));

  icache_array u_array (
    .clock(clock), .reset(reset), .flush(flush_cache), .lookup_pc(lookup_pc),
    .hit(hit), .hit_line(hit_line), .line_we(line_we), .line_index(line_index),
    .line_tag(line_tag), .line_data(line_data));

  refill_engine u_refill (
    .clock(clock), .reset(reset), .fill_req(fill_req), .fill_addr(fill_addr),
    .fill_uncached(fill_uncached), .fill_done(fill_done), .fill_line(fill_line),
    .fill_word(fill_word), .araddr(araddr), .arlen(arlen), .arvalid(arvalid),
    .arready(arready), .rdata(rdata), .rvalid(rvalid), .rready(rready), .rlast(rlast));

  fetch_queue #(.entry_t(fetch_pkg::fetch_entry_t), .DEPTH(2)) u_queue (
    .clock(clock), .reset(reset), .drop(drop), .push(push), .push_data(push_entry),
    .full(full), .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data));

  // Decode side fields
  assign out_pc    = out_data.pc;
  assign out_inst  = out_data.inst;
  assign out_fault = out_data.fault;

endmodule

`default_nettype wire

//--- tb/bus_memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module bus_memory_model (
  input  logic             clock,
  input  logic             reset,
  input  fetch_pkg::word_t araddr,
  input  logic [7:0]       arlen,
  input  logic             arvalid,
  output logic             arready,
  output fetch_pkg::word_t rdata,
  output logic             rvalid,
  input  logic             rready,
  output logic             rlast
);

  // Word at byte address a reads as a XOR this mask
  localparam logic [31:0] word_mask = 32'h5a5a_5a5a;

  fetch_pkg::word_t addr;
  int               beats_left;
  int               delay;

  initial begin
    arready = 1'b0;
    rdata   = '0;
    rvalid  = 1'b0;
    rlast   = 1'b0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One burst at a time, outputs move 1 ns after the edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always begin
    @(posedge clock);
    if (!reset && arvalid) begin
      delay = $urandom_range(0, 5);
      repeat (delay) @(posedge clock);
      #1;
      arready = 1'b1;
      // arvalid is held, so the handshake lands on this edge
      @(posedge clock);
      addr       = araddr;
      beats_left = int'(arlen) + 1;
      #1;
      arready = 1'b0;
      while (beats_left > 0) begin
        // Roughly one cycle in three is a gap
        if ($urandom_range(0, 2) == 0) begin
          rvalid = 1'b0;
        end else begin
          rvalid = 1'b1;
          rdata  = addr ^ word_mask;
          rlast  = (beats_left == 1);
        end
        @(posedge clock);
        if (rvalid && rready) begin
          addr       = addr + 32'd4;
          beats_left = beats_left - 1;
        end
        #1;
      end
      rvalid = 1'b0;
      rlast  = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch_top;

  localparam int max_cycles = 4000;
  localparam fetch_pkg::word_t reset_pc = `FETCH_RESET_PC;
  localparam fetch_pkg::word_t io_base = 32'h0f00_0000;

  logic             clock;
  logic             reset;
  logic             redirect;
  logic             flush_cache;
  fetch_pkg::word_t redirect_pc, araddr, rdata, out_pc, out_inst;
  logic [7:0]       arlen;
  logic             arvalid, arready, rvalid, rready, rlast;
  logic             out_valid, out_ready, out_fault;

  fetch_pkg::word_t        model_pc;
  fetch_pkg::fetch_entry_t exp_entry;
  fetch_pkg::word_t        read_addrs[$];
  logic [7:0]              read_lens[$];
  int accepted = 0;
  int check_count = 0;
  int error_count = 0;
  int test_errors = 0;
  int cycle_count = 0;
  int mark;
  int n_reads;

  fetch_top u_dut (
    .clock(clock), .reset(reset), .redirect(redirect), .redirect_pc(redirect_pc),
    .flush_cache(flush_cache), .araddr(araddr), .arlen(arlen), .arvalid(arvalid),
    .arready(arready), .rdata(rdata), .rvalid(rvalid), .rready(rready), .rlast(rlast),
    .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_inst(out_inst),
    .out_fault(out_fault));

  bus_memory_model u_memory (
    .clock(clock), .reset(reset), .araddr(araddr), .arlen(arlen), .arvalid(arvalid),
    .arready(arready), .rdata(rdata), .rvalid(rvalid), .rready(rready), .rlast(rlast));

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // Expected decode entry for a pc under the memory word rule
  function automatic fetch_pkg::fetch_entry_t expected_entry(input fetch_pkg::word_t pc,
                                                             input logic aligned);
    fetch_pkg::fetch_entry_t entry;
    entry.pc    = pc;
    entry.inst  = aligned ? (pc ^ 32'h5a5a_5a5a) : 32'h0;
    entry.fault = !aligned;
    return entry;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clock) begin
    if (!reset && arvalid && arready) begin
      read_addrs.push_back(araddr);
      read_lens.push_back(arlen);
    end
  end

  // Entry taken on a redirect edge still belongs to the old stream
  always @(posedge clock) begin
    if (reset) begin
      model_pc = reset_pc;
    end else begin
      if (out_valid && out_ready) begin
        exp_entry = expected_entry(model_pc, model_pc[1:0] == 2'b00);
        check_value("out_pc", exp_entry.pc, out_pc);
        check_value("out_inst", exp_entry.inst, out_inst);
        check_value("out_fault", 32'(exp_entry.fault), 32'(out_fault));
        accepted++;
        if (!exp_entry.fault) model_pc = model_pc + 32'd4;
      end
      if (redirect) model_pc = redirect_pc;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: run stopped after %0d cycles, %0d entries taken", cycle_count,
               accepted);
      $display("Errors found");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers entered 1 ns after an edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_redirect(input fetch_pkg::word_t pc);
    redirect    = 1'b1;
    redirect_pc = pc;
    @(posedge clock);
    #1;
    redirect = 1'b0;
  endtask

  task automatic pulse_flush();
    flush_cache = 1'b1;
    @(posedge clock);
    #1;
    flush_cache = 1'b0;
  endtask

  task automatic take_entries(input int count, input logic random_ready);
    int target;
    target = accepted + count;
    while (accepted < target) begin
      out_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
      @(posedge clock);
      #1;
    end
    out_ready = 1'b0;
  endtask

  // Bus idle long enough that no refill is left in flight
  task automatic settle();
    int quiet;
    quiet = 0;
    while (quiet < 8) begin
      @(posedge clock);
      #1;
      quiet = (arvalid || rready) ? 0 : quiet + 1;
    end
  endtask

  // Reads since mark that hit the four lines at the reset pc
  task automatic check_line_reads(input string name, input int expected);
    int hits;
    hits = 0;
    for (int i = mark; i < read_addrs.size(); i++) begin
      if (read_addrs[i] >= reset_pc && read_addrs[i] < reset_pc + 32'h40) begin
        hits++;
        check_value("arlen", 32'd3, 32'(read_lens[i]));
      end
    end
    check_value(name, 32'(expected), 32'(hits));
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d failures", num, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  initial begin
    void'($urandom(32'h88b3_a312));
    reset       = 1'b1;
    redirect    = 1'b0;
    redirect_pc = '0;
    flush_cache = 1'b0;
    out_ready   = 1'b0;
    repeat (8) @(posedge clock);
    #1;
    check_value("arvalid", 32'd0, 32'(arvalid));
    check_value("rready", 32'd0, 32'(rready));
    check_value("out_valid", 32'd0, 32'(out_valid));
    reset = 1'b0;

    take_entries(24, 1'b0);
    report_test(1, "sequential fetch");

    // Warm pass stops short so the line after the loop is never fetched
    send_redirect(reset_pc);
    take_entries(13, 1'b0);
    mark = read_addrs.size();
    send_redirect(reset_pc);
    take_entries(16, 1'b0);
    check_line_reads("loop line reads", 0);
    report_test(2, "loop reuse");

    settle();
    mark = read_addrs.size();
    pulse_flush();
    send_redirect(reset_pc);
    take_entries(16, 1'b0);
    check_line_reads("line bursts", 4);
    report_test(3, "flush");

    settle();
    mark = read_addrs.size();
    send_redirect(io_base);
    take_entries(6, 1'b0);
    n_reads = read_addrs.size() - mark;
    check_value("uncached reads", 32'd6, 32'(n_reads));
    for (int i = 0; i < 6 && i < n_reads; i++) begin
      check_value("araddr", io_base + 32'(4 * i), read_addrs[mark + i]);
      check_value("arlen", 32'd0, 32'(read_lens[mark + i]));
    end
    report_test(4, "uncached region");

    settle();
    mark = read_addrs.size();
    send_redirect(reset_pc + 32'd2);
    take_entries(1, 1'b0);
    repeat (10) @(posedge clock);
    #1;
    check_value("out_valid", 32'd0, 32'(out_valid));
    check_value("reads after fault", 32'd0, 32'(read_addrs.size() - mark));
    send_redirect(reset_pc);
    take_entries(4, 1'b0);
    report_test(5, "misaligned redirect");

    send_redirect(reset_pc + 32'h100);
    take_entries(20, 1'b1);
    while (!(arvalid || rready)) begin
      out_ready = 1'($urandom_range(0, 1));
      @(posedge clock);
      #1;
    end
    send_redirect(reset_pc + 32'h200);
    take_entries(20, 1'b1);
    report_test(6, "back-pressure and redirect");

    $display("summary: %0d checks, %0d failures, %0d entries, %0d bus reads", check_count,
             error_count, accepted, read_addrs.size());
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/fetch_pkg.sv
src/fetch_sequencer.sv
src/icache_array.sv
src/refill_engine.sv
src/fetch_queue.sv
src/fetch_top.sv
tb/bus_memory_model.sv
tb/tb_fetch_top.sv
